//--- rtl/rv_exec_pkg.sv
package rv_exec_pkg;

    // data path width, one register word
    localparam int xlen = 32;

    // operation code: modifier, group, operation
    typedef struct packed {
        logic       modf;   // sub / arithmetic shift select
        logic [2:0] grp;
        logic [2:0] op;
    } aluctl_t;

    // bit 6 of the operation code
    localparam logic [6:0] ALU_MOD = 7'b100_0000;

    // integer group 000; group 100 reuses the low three bits
    localparam logic [5:0] ALU_ADD  = 6'b000_000;
    localparam logic [5:0] ALU_SLL  = 6'b000_001;
    localparam logic [5:0] ALU_SR   = 6'b000_010;  // srl, sra with modifier
    localparam logic [5:0] ALU_SLT  = 6'b000_011;
    localparam logic [5:0] ALU_SLTU = 6'b000_100;
    localparam logic [5:0] ALU_XOR  = 6'b000_101;
    localparam logic [5:0] ALU_OR   = 6'b000_110;
    localparam logic [5:0] ALU_AND  = 6'b000_111;

    // upper immediate
    localparam logic [5:0] ALU_LUI  = 6'b101_010;

    // store data goes through unchanged
    localparam logic [5:0] ALU_SW   = 6'b110_110;
    localparam logic [5:0] ALU_FSW  = 6'b110_111;

    // branch conditions, result is the taken flag
    localparam logic [5:0] BR_EQ    = 6'b110_000;
    localparam logic [5:0] BR_NE    = 6'b110_001;
    localparam logic [5:0] BR_LT    = 6'b110_010;
    localparam logic [5:0] BR_GE    = 6'b110_011;
    localparam logic [5:0] BR_LTU   = 6'b110_100;
    localparam logic [5:0] BR_GEU   = 6'b110_101;

    // one issued operation
    typedef struct packed {
        aluctl_t         ctl;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        logic [4:0]      rd;    // destination tag, carried along
    } issue_t;

    // what goes on to writeback
    typedef struct packed {
        logic [xlen-1:0] res;
        logic [4:0]      rd;
        logic            is_branch;
        logic            taken;
    } exec_result_t;

endpackage

//--- rtl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic up_valid,
    output logic up_ready,
    input  T     up_data,
    output logic dn_valid,
    input  logic dn_ready,
    output T     dn_data
);

    logic full;
    logic load;
    T     slot;

    // no skid buffer, a stalled full slot blocks upstream directly
    assign up_ready = !full || dn_ready;
    assign load     = up_valid && up_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (dn_ready) begin
            full <= 1'b0;   // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            slot <= up_data;
        end
    end

    assign dn_valid = full;
    assign dn_data  = slot;

endmodule

//--- rtl/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    input  rv_exec_pkg::aluctl_t           ctl,
    input  logic [rv_exec_pkg::xlen-1:0] op1,
    input  logic [rv_exec_pkg::xlen-1:0] op2,
    output logic [rv_exec_pkg::xlen-1:0] res
);

    import rv_exec_pkg::*;

    logic [5:0]      base;
    logic            modf;
    logic            sub_sel;
    logic [4:0]      shamt;
    logic [xlen-1:0] add_sub;
    logic [xlen-1:0] sll_r;
    logic [xlen-1:0] sr_r;
    logic [xlen-1:0] slt_r;
    logic [xlen-1:0] sltu_r;
    logic [xlen-1:0] xor_r;
    logic [xlen-1:0] or_r;
    logic [xlen-1:0] and_r;
    logic [xlen-1:0] lui_r;
    logic [xlen-1:0] arith_r;

    assign base  = {ctl.grp, ctl.op};
    assign modf  = |(ctl & ALU_MOD);
    assign shamt = op2[4:0];

    // immediate group has no subtract
    assign sub_sel = modf && (ctl.grp == 3'b000);
    assign add_sub = sub_sel ? op1 - op2 : op1 + op2;

    assign sll_r  = op1 << shamt;
    assign slt_r  = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
    assign sltu_r = {{(xlen-1){1'b0}}, op1 < op2};
    assign xor_r  = op1 ^ op2;
    assign or_r   = op1 | op2;
    assign and_r  = op1 & op2;

    // low halves of op2 and op1 side by side
    assign lui_r = {op2[15:0], op1[15:0]};

    // modifier picks arithmetic shift in both groups
    always_comb begin
        if (modf) begin
            sr_r = $signed(op1) >>> shamt;
        end else begin
            sr_r = op1 >> shamt;
        end
    end

    // shared by register and immediate groups
    always_comb begin
        unique case (ctl.op)
            ALU_ADD[2:0]:  arith_r = add_sub;
            ALU_SLL[2:0]:  arith_r = sll_r;
            ALU_SR[2:0]:   arith_r = sr_r;
            ALU_SLT[2:0]:  arith_r = slt_r;
            ALU_SLTU[2:0]: arith_r = sltu_r;
            ALU_XOR[2:0]:  arith_r = xor_r;
            ALU_OR[2:0]:   arith_r = or_r;
            ALU_AND[2:0]:  arith_r = and_r;
            default:       arith_r = '0;
        endcase
    end

    always_comb begin
        unique case (ctl.grp)
            3'b000, 3'b100: res = arith_r;
            3'b001: res = '0;   // mul / div not built
            3'b010: res = '0;   // fp arithmetic
            3'b011: res = '0;   // fp compare and moves
            3'b101: begin
                // loads are handled elsewhere
                if (base == ALU_LUI) begin
                    res = lui_r;
                end else begin
                    res = '0;
                end
            end
            3'b110: begin
                if (base == ALU_SW || base == ALU_FSW) begin
                    res = op2;  // store data
                end else begin
                    res = '0;   // branches only set flags
                end
            end
            3'b111: res = '0;   // jumps live in another stage
            default: res = '0;
        endcase
    end

endmodule

//--- rtl/branch_cond.sv
`timescale 1ns/1ps

module branch_cond (
    input  rv_exec_pkg::aluctl_t           ctl,
    input  logic [rv_exec_pkg::xlen-1:0] op1,
    input  logic [rv_exec_pkg::xlen-1:0] op2,
    output logic                           is_branch,
    output logic                           taken
);

    import rv_exec_pkg::*;

    logic [5:0] base;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign base = {ctl.grp, ctl.op};   // modifier bit plays no part

    assign eq   = op1 == op2;
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb begin
        is_branch = 1'b1;
        unique case (base)
            BR_EQ:  taken = eq;
            BR_NE:  taken = !eq;
            BR_LT:  taken = lt_s;
            BR_GE:  taken = !lt_s;
            BR_LTU: taken = lt_u;
            BR_GEU: taken = !lt_u;
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/rv_exec.sv
`timescale 1ns/1ps

module rv_exec (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  rv_exec_pkg::issue_t       in_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output rv_exec_pkg::exec_result_t out_data
);

    import rv_exec_pkg::*;

    issue_t          issue_q;
    logic            issue_valid;
    logic            result_ready;
    logic [xlen-1:0] alu_res;
    logic            is_branch;
    logic            taken;
    exec_result_t    result_d;

    // first slot, registered operation
    stage_reg #(.T(issue_t)) u_issue_reg (
        .clk      (clk),
        .rst      (rst),
        .up_valid (in_valid),
        .up_ready (in_ready),
        .up_data  (in_data),
        .dn_valid (issue_valid),
        .dn_ready (result_ready),
        .dn_data  (issue_q)
    );

    exec_alu u_alu (
        .ctl (issue_q.ctl),
        .op1 (issue_q.op1),
        .op2 (issue_q.op2),
        .res (alu_res)
    );

    branch_cond u_branch (
        .ctl       (issue_q.ctl),
        .op1       (issue_q.op1),
        .op2       (issue_q.op2),
        .is_branch (is_branch),
        .taken     (taken)
    );

    always_comb begin
        result_d.res       = alu_res;
        result_d.rd        = issue_q.rd;
        result_d.is_branch = is_branch;
        result_d.taken     = taken;
    end

    // second slot, held for writeback
    stage_reg #(.T(exec_result_t)) u_result_reg (
        .clk      (clk),
        .rst      (rst),
        .up_valid (issue_valid),
        .up_ready (result_ready),
        .up_data  (result_d),
        .dn_valid (out_valid),
        .dn_ready (out_ready),
        .dn_data  (out_data)
    );

endmodule

//--- dv/rv_exec_asserts.sv
`timescale 1ns/1ps

module rv_exec_asserts (
    input logic                         clk,
    input logic                         rst,
    input logic                         in_valid,
    input logic                         in_ready,
    input rv_exec_pkg::issue_t          in_data,
    input logic                         out_valid,
    input logic                         out_ready,
    input rv_exec_pkg::exec_result_t    out_data,
    input logic                         slot_valid,
    input rv_exec_pkg::aluctl_t         alu_ctl,
    input logic [rv_exec_pkg::xlen-1:0] alu_op1,
    input logic [rv_exec_pkg::xlen-1:0] alu_op2,
    input logic [rv_exec_pkg::xlen-1:0] alu_res,
    input logic                         br_flag,
    input logic                         br_taken
);

    import rv_exec_pkg::*;

    logic            fail_res;
    logic            fail_br;
    logic            fail_rst;
    logic            fail_hold;
    logic            fail_full;
    logic            fail_lat;
    logic            fail_order;
    logic            fail_out;
    logic            failed;
    logic [xlen-1:0] exp_res;
    logic [1:0]      exp_br;      // is_branch, taken
    logic [xlen+1:0] exp_tab [32];   // model result and flags by tag
    logic            rst_q;
    logic            lat1_q;
    logic            lat2_q;
    logic [4:0]      rd1_q;
    logic [4:0]      rd2_q;
    logic            have_prev;
    logic [4:0]      prev_rd;

    // integer table: groups 000 and 100, lui, store data, zero elsewhere
    function automatic logic [xlen-1:0] model_res(input logic [6:0] code,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        logic [2:0] grp;
        logic [4:0] sh;
        grp       = code[5:3];
        sh        = b[4:0];
        model_res = '0;
        if (grp == 3'b000 || grp == 3'b100) begin
            case (code[2:0])
                3'd0: model_res = (code[6] && grp == 3'b000) ? a - b : a + b;
                3'd1: model_res = a << sh;
                3'd2: begin
                    if (code[6]) begin
                        model_res = $signed(a) >>> sh;   // sign fill
                    end else begin
                        model_res = a >> sh;
                    end
                end
                3'd3: model_res = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
                3'd4: model_res = {{(xlen-1){1'b0}}, a < b};
                3'd5: model_res = a ^ b;
                3'd6: model_res = a | b;
                default: model_res = a & b;
            endcase
        end else if (code[5:0] == ALU_LUI) begin
            model_res = {b[15:0], a[15:0]};
        end else if (code[5:0] == ALU_SW || code[5:0] == ALU_FSW) begin
            model_res = b;
        end
    endfunction

    function automatic logic [1:0] model_br(input logic [6:0] code,
                                            input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
        case (code[5:0])
            BR_EQ:   model_br = {1'b1, a == b};
            BR_NE:   model_br = {1'b1, a != b};
            BR_LT:   model_br = {1'b1, $signed(a) < $signed(b)};
            BR_GE:   model_br = {1'b1, $signed(a) >= $signed(b)};
            BR_LTU:  model_br = {1'b1, a < b};
            BR_GEU:  model_br = {1'b1, a >= b};
            default: model_br = 2'b00;
        endcase
    endfunction

    initial begin
        fail_res   = 1'b0;
        fail_br    = 1'b0;
        fail_rst   = 1'b0;
        fail_hold  = 1'b0;
        fail_full  = 1'b0;
        fail_lat   = 1'b0;
        fail_order = 1'b0;
        fail_out   = 1'b0;
    end

    assign failed  = fail_res | fail_br | fail_rst | fail_hold | fail_full | fail_lat
                   | fail_order | fail_out;
    assign exp_res = model_res(alu_ctl, alu_op1, alu_op2);
    assign exp_br  = model_br(alu_ctl, alu_op1, alu_op2);

    // latency window and delivery history
    always_ff @(posedge clk) begin
        rst_q <= rst;
        rd1_q <= in_data.rd;
        rd2_q <= rd1_q;
        if (in_valid && in_ready) begin
            exp_tab[in_data.rd] <= {model_res(in_data.ctl, in_data.op1, in_data.op2),
                                    model_br(in_data.ctl, in_data.op1, in_data.op2)};
        end
        if (rst) begin
            lat1_q    <= 1'b0;
            lat2_q    <= 1'b0;
            have_prev <= 1'b0;
        end else begin
            lat1_q <= in_valid && in_ready && out_ready;
            lat2_q <= lat1_q && out_ready;   // ready held through the window
            if (out_valid && out_ready) begin
                have_prev <= 1'b1;
                prev_rd   <= out_data.rd;
            end
        end
    end

    a_alu_result: assert property (@(posedge clk) disable iff (rst)
        slot_valid |-> alu_res == exp_res)
        else begin
            fail_res = 1'b1;
            $error("alu result wrong for code %b", alu_ctl);
        end

    a_branch_flags: assert property (@(posedge clk) disable iff (rst)
        slot_valid |-> {br_flag, br_taken} == exp_br)
        else begin
            fail_br = 1'b1;
            $error("branch flags wrong for code %b", alu_ctl);
        end

    a_out_result: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> {out_data.res, out_data.is_branch, out_data.taken}
                      == exp_tab[out_data.rd])
        else begin
            fail_out = 1'b1;
            $error("writeback result wrong for tag %0d", out_data.rd);
        end

    a_reset_state: assert property (@(posedge clk)
        rst_q && !rst |-> !out_valid && in_ready)
        else begin
            fail_rst = 1'b1;
            $error("stage not empty after reset");
        end

    a_hold_output: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            fail_hold = 1'b1;
            $error("output changed while stalled");
        end

    a_full_blocks: assert property (@(posedge clk) disable iff (rst)
        slot_valid && out_valid && !out_ready |-> !in_ready)
        else begin
            fail_full = 1'b1;
            $error("in_ready high with both slots full");
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        lat2_q |-> out_valid && out_data.rd == rd2_q)
        else begin
            fail_lat = 1'b1;
            $error("operation not delivered two edges after issue");
        end

    a_in_order: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && have_prev |-> out_data.rd == prev_rd + 5'd1)
        else begin
            fail_order = 1'b1;
            $error("delivered tag %0d out of sequence", out_data.rd);
        end

endmodule

bind rv_exec rv_exec_asserts u_chk (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .slot_valid (u_issue_reg.dn_valid),
    .alu_ctl    (u_alu.ctl),
    .alu_op1    (u_alu.op1),
    .alu_op2    (u_alu.op2),
    .alu_res    (u_alu.res),
    .br_flag    (u_branch.is_branch),
    .br_taken   (u_branch.taken)
);

//--- dv/rv_exec_tb.sv
`timescale 1ns/1ps

module rv_exec_tb;

    import rv_exec_pkg::*;

    localparam int dir_ops   = 2 * 25 * 5 * 5;   // modifier, base codes, operand pairs
    localparam int rand_ops  = 400;
    localparam int stall_ops = 300;
    localparam int wd_cycles = (dir_ops + rand_ops + stall_ops) * 4 + 200;

    logic         clk;
    logic         rst;
    logic         in_valid;
    logic         in_ready;
    issue_t       in_data;
    logic         out_valid;
    logic         out_ready;
    exec_result_t out_data;

    integer      seed = 32'ha9265fca;
    logic        stall_mode;
    logic [4:0]  next_rd;
    int          accepted;
    int          delivered;
    logic [5:0]  base_codes [25];
    logic [31:0] corners [5];
    string       why;

    rv_exec dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #20 clk = ~clk;

    // transfer counters on both sides
    always @(posedge clk) begin
        if (rst) begin
            accepted  <= 0;
            delivered <= 0;
        end else begin
            if (in_valid && in_ready) begin
                accepted <= accepted + 1;
            end
            if (out_valid && out_ready) begin
                delivered <= delivered + 1;
            end
        end
    end

    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        r         = $random(seed);
        out_ready = stall_mode ? (r[3:0] > 4'd5) : 1'b1;   // ready about 60 percent
    endtask

    // hold the operation until the stage takes it
    task automatic send_op(input logic [6:0] code, input logic [31:0] a, input logic [31:0] b);
        int start;
        start       = accepted;
        in_data.ctl = aluctl_t'(code);
        in_data.op1 = a;
        in_data.op2 = b;
        in_data.rd  = next_rd;
        in_valid    = 1'b1;
        do begin
            next_cycle();
        end while (accepted == start);
        next_rd = next_rd + 5'd1;
    endtask

    task automatic send_random();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = $random(seed);
        a = $random(seed);
        b = $random(seed);
        send_op(r[6:0], a, b);   // any of the 128 codes
    endtask

    initial begin
        logic [31:0] r;
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b1;
        stall_mode = 1'b0;
        next_rd    = '0;
        for (int i = 0; i < 8; i++) begin
            base_codes[i]     = {3'b000, 3'(i)};
            base_codes[i + 8] = {3'b100, 3'(i)};
        end
        base_codes[16] = ALU_LUI;
        base_codes[17] = ALU_SW;
        base_codes[18] = ALU_FSW;
        for (int i = 0; i < 6; i++) begin
            base_codes[19 + i] = BR_EQ + 6'(i);   // six consecutive branch codes
        end
        corners = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_001f, 32'h7fff_ffff};
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // corner operands on every defined code
        for (int m = 0; m < 2; m++) begin
            for (int c = 0; c < 25; c++) begin
                for (int i = 0; i < 5; i++) begin
                    for (int j = 0; j < 5; j++) begin
                        send_op({m[0], base_codes[c]}, corners[i], corners[j]);
                    end
                end
            end
        end

        repeat (rand_ops) send_random();

        // stalls and idle gaps
        stall_mode = 1'b1;
        repeat (stall_ops) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                in_valid = 1'b0;
                repeat (r[3:2] + 1) next_cycle();
            end
            send_random();
        end
        in_valid   = 1'b0;
        stall_mode = 1'b0;
        while (out_valid || dut.u_issue_reg.dn_valid) begin
            next_cycle();
        end
        repeat (3) next_cycle();

        if (accepted != delivered) begin
            $display("operation count wrong: %0d accepted, %0d delivered", accepted, delivered);
            $display("ERRORS FOUND");
            $fatal(1, "count check failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    initial begin
        wait (dut.u_chk.failed === 1'b1);
        case (1'b1)
            dut.u_chk.fail_res:   why = "alu result differs from the reference model";
            dut.u_chk.fail_br:    why = "branch flags differ from the reference model";
            dut.u_chk.fail_out:   why = "writeback result differs from the reference model";
            dut.u_chk.fail_rst:   why = "stage not empty after reset";
            dut.u_chk.fail_hold:  why = "output not held during back-pressure";
            dut.u_chk.fail_full:  why = "in_ready high with both slots full";
            dut.u_chk.fail_lat:   why = "result not delivered after two edges";
            dut.u_chk.fail_order: why = "delivered tag out of order";
            default:              why = "unnamed assertion";
        endcase
        $display("MISMATCH at %0t: %s", $time, why);
        $display("ERRORS FOUND");
        $fatal(1, "assertion failed");
    end

    // watchdog sized from the operation count
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- rv_exec.f
rtl/rv_exec_pkg.sv
rtl/stage_reg.sv
rtl/exec_alu.sv
rtl/branch_cond.sv
rtl/rv_exec.sv
dv/rv_exec_asserts.sv
dv/rv_exec_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_exec testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert --top-module rv_exec_tb \
    -f rv_exec.f --Mdir obj_dir -o rv_exec_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/rv_exec_sim +verilator+error+limit+100 2>&1)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
